//--- hdl/box_filter.sv
`timescale 1ns/1ns

module box_filter import overlay_pkg::*; #(
    parameter coord_t NO_BOX = coord_t'(641)
) (
    input  coord_t  hold_min_x_i [REGIONS],
    input  coord_t  hold_max_x_i [REGIONS],
    input  coord_t  hold_min_y_i [REGIONS],
    input  coord_t  hold_max_y_i [REGIONS],
    input  thresh_t area_thresh_i,
    output logic    box_valid_o  [REGIONS]
);

    // One extra bit so a full-width span fits
    localparam int SPAN_W = $bits(coord_t) + 1;

    area_t             eff_thresh;
    logic              present [REGIONS];
    logic [SPAN_W-1:0] width   [REGIONS];
    logic [SPAN_W-1:0] height  [REGIONS];
    area_t             area    [REGIONS];

    assign eff_thresh = (area_thresh_i == '0) ? area_t'(DEFAULT_AREA_THRESH)
                                              : area_t'(area_thresh_i);

    always_comb begin
        for (int i = 0; i < REGIONS; i++) begin
            present[i] = (hold_min_x_i[i] != NO_BOX) && (hold_min_y_i[i] != NO_BOX) &&
                         (hold_max_x_i[i] >= hold_min_x_i[i]) &&
                         (hold_max_y_i[i] >= hold_min_y_i[i]);

            if (present[i]) begin
                width[i]  = SPAN_W'(hold_max_x_i[i]) - SPAN_W'(hold_min_x_i[i]) + SPAN_W'(1);
                height[i] = SPAN_W'(hold_max_y_i[i]) - SPAN_W'(hold_min_y_i[i]) + SPAN_W'(1);
                area[i]   = area_t'(width[i]) * area_t'(height[i]);
            end else begin
                width[i]  = '0;
                height[i] = '0;
                area[i]   = '0;
            end

            // Threshold is never zero, so an absent box always fails
            box_valid_o[i] = (area[i] >= eff_thresh);
        end
    end

endmodule

//--- hdl/box_outline.sv
`timescale 1ns/1ns

module box_outline import overlay_pkg::*; (
    input  coord_t draw_x_i,
    input  coord_t draw_y_i,
    input  logic   active_i,
    input  logic   mark_en_i,
    input  coord_t hold_min_x_i [REGIONS],
    input  coord_t hold_max_x_i [REGIONS],
    input  coord_t hold_min_y_i [REGIONS],
    input  coord_t hold_max_y_i [REGIONS],
    input  logic   box_valid_i  [REGIONS],
    input  pixel_t pixel_i,
    output pixel_t red_o,
    output pixel_t green_o,
    output pixel_t blue_o
);

    logic [REGIONS-1:0] hit;
    logic               any_hit;
    mark_e              mark;

    ////////////////////////////////
    // Border hit test
    ////////////////////////////////

    for (genvar i = 0; i < REGIONS; i++) begin : g_region
        logic in_x;
        logic in_y;
        logic on_row;
        logic on_col;

        assign in_x = (draw_x_i >= hold_min_x_i[i]) && (draw_x_i <= hold_max_x_i[i]);
        assign in_y = (draw_y_i >= hold_min_y_i[i]) && (draw_y_i <= hold_max_y_i[i]);

        // Top/bottom edge and left/right edge
        assign on_row = (draw_y_i == hold_min_y_i[i]) || (draw_y_i == hold_max_y_i[i]);
        assign on_col = (draw_x_i == hold_min_x_i[i]) || (draw_x_i == hold_max_x_i[i]);

        assign hit[i] = box_valid_i[i] && ((on_row && in_x) || (on_col && in_y));
    end

    assign any_hit = |hit;

    ////////////////////////////////
    // Colour select
    ////////////////////////////////

    assign mark = (any_hit && mark_en_i && active_i) ? MARK_RED : MARK_NONE;

    always_comb begin
        case (mark)
            MARK_RED: begin
                red_o   = '1;
                green_o = '0;
                blue_o  = '0;
            end
            default: begin
                red_o   = pixel_i;
                green_o = pixel_i;
                blue_o  = pixel_i;
            end
        endcase
    end

endmodule

//--- hdl/box_overlay_top.sv
`timescale 1ns/1ns

module box_overlay_top import overlay_pkg::*; #(
    parameter int H_ACTIVE  = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_ACTIVE  = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33,
    parameter int FRAME_DIV = 5
) (
    input  logic    clk,
    input  logic    reset,
    input  coord_t  box_min_x_i [REGIONS],
    input  coord_t  box_max_x_i [REGIONS],
    input  coord_t  box_min_y_i [REGIONS],
    input  coord_t  box_max_y_i [REGIONS],
    input  thresh_t area_thresh_i,
    input  logic    mark_en_i,
    input  pixel_t  pixel_i,
    output logic    hsync_o,
    output logic    vsync_o,
    output logic    active_o,
    output coord_t  draw_x_o,
    output coord_t  draw_y_o,
    output pixel_t  red_o,
    output pixel_t  green_o,
    output pixel_t  blue_o
);

    // Just past the right edge of active video
    localparam coord_t NO_BOX = coord_t'(H_ACTIVE + 1);

    coord_t hold_min_x [REGIONS];
    coord_t hold_max_x [REGIONS];
    coord_t hold_min_y [REGIONS];
    coord_t hold_max_y [REGIONS];
    logic   box_valid  [REGIONS];

    raster_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) u_raster (
        .clk      (clk),
        .reset    (reset),
        .draw_x_o (draw_x_o),
        .draw_y_o (draw_y_o),
        .hsync_o  (hsync_o),
        .vsync_o  (vsync_o),
        .active_o (active_o)
    );

    box_sampler #(
        .FRAME_DIV (FRAME_DIV),
        .NO_BOX    (NO_BOX)
    ) u_sampler (
        .clk          (clk),
        .reset        (reset),
        .vsync_i      (vsync_o),
        .box_min_x_i  (box_min_x_i),
        .box_max_x_i  (box_max_x_i),
        .box_min_y_i  (box_min_y_i),
        .box_max_y_i  (box_max_y_i),
        .hold_min_x_o (hold_min_x),
        .hold_max_x_o (hold_max_x),
        .hold_min_y_o (hold_min_y),
        .hold_max_y_o (hold_max_y)
    );

    box_filter #(
        .NO_BOX (NO_BOX)
    ) u_filter (
        .hold_min_x_i  (hold_min_x),
        .hold_max_x_i  (hold_max_x),
        .hold_min_y_i  (hold_min_y),
        .hold_max_y_i  (hold_max_y),
        .area_thresh_i (area_thresh_i),
        .box_valid_o   (box_valid)
    );

    box_outline u_outline (
        .draw_x_i     (draw_x_o),
        .draw_y_i     (draw_y_o),
        .active_i     (active_o),
        .mark_en_i    (mark_en_i),
        .hold_min_x_i (hold_min_x),
        .hold_max_x_i (hold_max_x),
        .hold_min_y_i (hold_min_y),
        .hold_max_y_i (hold_max_y),
        .box_valid_i  (box_valid),
        .pixel_i      (pixel_i),
        .red_o        (red_o),
        .green_o      (green_o),
        .blue_o       (blue_o)
    );

endmodule

//--- hdl/box_sampler.sv
`timescale 1ns/1ns

module box_sampler import overlay_pkg::*; #(
    parameter int     FRAME_DIV = 5,
    parameter coord_t NO_BOX    = coord_t'(641)
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   vsync_i,
    input  coord_t box_min_x_i  [REGIONS],
    input  coord_t box_max_x_i  [REGIONS],
    input  coord_t box_min_y_i  [REGIONS],
    input  coord_t box_max_y_i  [REGIONS],
    output coord_t hold_min_x_o [REGIONS],
    output coord_t hold_max_x_o [REGIONS],
    output coord_t hold_min_y_o [REGIONS],
    output coord_t hold_max_y_o [REGIONS]
);

    localparam int DIV_W = (FRAME_DIV > 1) ? $clog2(FRAME_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(FRAME_DIV - 1);

    logic             vsync_q1;
    logic             vsync_q2;
    logic             vsync_start;
    logic             sample;
    logic [DIV_W-1:0] frame_cnt;

    ////////////////////////////////
    // Frame event
    ////////////////////////////////

    // Idle high so reset does not look like a sync start
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vsync_q1 <= 1'b1;
            vsync_q2 <= 1'b1;
        end else begin
            vsync_q1 <= vsync_i;
            vsync_q2 <= vsync_q1;
        end
    end

    assign vsync_start = vsync_q2 & ~vsync_q1;
    assign sample      = vsync_start && (frame_cnt == DIV_LAST);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_cnt <= '0;
        end else if (sample) begin
            frame_cnt <= '0;
        end else if (vsync_start) begin
            frame_cnt <= frame_cnt + DIV_W'(1);
        end
    end

    ////////////////////////////////
    // Holding registers
    ////////////////////////////////

    // Empty box until the first sample lands
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < REGIONS; i++) begin
                hold_min_x_o[i] <= NO_BOX;
                hold_max_x_o[i] <= '0;
                hold_min_y_o[i] <= NO_BOX;
                hold_max_y_o[i] <= '0;
            end
        end else if (sample) begin
            for (int i = 0; i < REGIONS; i++) begin
                hold_min_x_o[i] <= box_min_x_i[i];
                hold_max_x_o[i] <= box_max_x_i[i];
                hold_min_y_o[i] <= box_min_y_i[i];
                hold_max_y_o[i] <= box_max_y_i[i];
            end
        end
    end

endmodule

//--- hdl/overlay_pkg.sv
package overlay_pkg;

    // 4 columns by 3 rows, index = row * 4 + column
    localparam int REGIONS = 12;

    // Screen coordinate, wide enough for 640x480
    typedef logic [9:0] coord_t;

    // One grey-level colour channel
    typedef logic [6:0] pixel_t;

    // Box area, covers a full frame
    typedef logic [21:0] area_t;

    // Area threshold as supplied from outside
    typedef logic [14:0] thresh_t;

    // Used when the threshold input is zero
    localparam int DEFAULT_AREA_THRESH = 16;

    // Per-pixel colour decision
    typedef enum logic {
        MARK_NONE,
        MARK_RED
    } mark_e;

endpackage

//--- hdl/raster_timing.sv
`timescale 1ns/1ns

module raster_timing import overlay_pkg::*; #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic   clk,
    input  logic   reset,
    output coord_t draw_x_o,
    output coord_t draw_y_o,
    output logic   hsync_o,
    output logic   vsync_o,
    output logic   active_o
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam coord_t H_LAST = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST = coord_t'(V_TOTAL - 1);

    // Sync windows, start inclusive and end exclusive
    localparam coord_t H_SYNC_START = coord_t'(H_ACTIVE + H_FRONT);
    localparam coord_t H_SYNC_END   = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam coord_t V_SYNC_START = coord_t'(V_ACTIVE + V_FRONT);
    localparam coord_t V_SYNC_END   = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

    coord_t x_cnt;
    coord_t y_cnt;

    ////////////////////////////////
    // Position counters
    ////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (x_cnt == H_LAST) begin
            x_cnt <= '0;
            if (y_cnt == V_LAST) begin
                y_cnt <= '0;
            end else begin
                y_cnt <= y_cnt + coord_t'(1);
            end
        end else begin
            x_cnt <= x_cnt + coord_t'(1);
        end
    end

    ////////////////////////////////
    // Sync and blanking
    ////////////////////////////////

    // Both syncs are active low
    assign hsync_o = ~((x_cnt >= H_SYNC_START) && (x_cnt < H_SYNC_END));
    assign vsync_o = ~((y_cnt >= V_SYNC_START) && (y_cnt < V_SYNC_END));

    assign active_o = (x_cnt < coord_t'(H_ACTIVE)) && (y_cnt < coord_t'(V_ACTIVE));

    assign draw_x_o = x_cnt;
    assign draw_y_o = y_cnt;

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_box_overlay -o tb_box_overlay

# The simulator exits non-zero on a failed check, so the grep decides
out=$(./obj_dir/tb_box_overlay) || true
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS"

//--- src.f
hdl/overlay_pkg.sv
hdl/raster_timing.sv
hdl/box_sampler.sv
hdl/box_filter.sv
hdl/box_outline.sv
hdl/box_overlay_top.sv
test/tb_box_overlay.sv

//--- test/tb_box_overlay.sv
`timescale 1ns/1ns

module tb_box_overlay;

    localparam int N            = 12;
    localparam int H_TOTAL      = 24;
    localparam int V_TOTAL      = 16;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int NO_BOX       = 17;
    localparam int DEF_THRESH   = 16;
    // Covers about 18 frames of tests with ample margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic        clk;
    logic        reset;
    logic [9:0]  box_min_x [N];
    logic [9:0]  box_max_x [N];
    logic [9:0]  box_min_y [N];
    logic [9:0]  box_max_y [N];
    logic [14:0] area_thresh;
    logic        mark_en;
    logic [6:0]  pixel;
    logic        hsync;
    logic        vsync;
    logic        active;
    logic [9:0]  draw_x;
    logic [9:0]  draw_y;
    logic [6:0]  red;
    logic [6:0]  green;
    logic [6:0]  blue;

    // Boxes the DUT should hold after a sample
    int lat_min_x [N];
    int lat_max_x [N];
    int lat_min_y [N];
    int lat_max_y [N];
    int seed   = 80;
    int cycles = 0;

    box_overlay_top #(
        .H_ACTIVE (16), .H_FRONT (2), .H_SYNC (3), .H_BACK (3),
        .V_ACTIVE (12), .V_FRONT (1), .V_SYNC (2), .V_BACK (1)
    ) dut (
        .clk (clk), .reset (reset),
        .box_min_x_i (box_min_x), .box_max_x_i (box_max_x),
        .box_min_y_i (box_min_y), .box_max_y_i (box_max_y),
        .area_thresh_i (area_thresh), .mark_en_i (mark_en), .pixel_i (pixel),
        .hsync_o (hsync), .vsync_o (vsync), .active_o (active),
        .draw_x_o (draw_x), .draw_y_o (draw_y),
        .red_o (red), .green_o (green), .blue_o (blue)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Random grey background that changes every cycle
    always @(posedge clk) begin
        #5;
        pixel = 7'($random(seed));
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "Run timed out");
        end
    end

    task automatic check_value(string test, string what, logic [31:0] expected,
                               logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error [%s] %s: expected %0d, actual %0d", test, what, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "Mismatch in test %s", test);
        end
    endtask

    task automatic drive_box(int i, int mnx, int mxx, int mny, int mxy);
        box_min_x[i] = 10'(mnx);
        box_max_x[i] = 10'(mxx);
        box_min_y[i] = 10'(mny);
        box_max_y[i] = 10'(mxy);
    endtask

    task automatic clear_boxes();
        for (int i = 0; i < N; i++) begin
            drive_box(i, NO_BOX, 0, NO_BOX, 0);
        end
    endtask

    task automatic latch_model();
        for (int i = 0; i < N; i++) begin
            lat_min_x[i] = int'(box_min_x[i]);
            lat_max_x[i] = int'(box_max_x[i]);
            lat_min_y[i] = int'(box_min_y[i]);
            lat_max_y[i] = int'(box_max_y[i]);
        end
    endtask

    // A sample lands within any five vsync starts
    task automatic wait_sample();
        repeat (6) @(negedge vsync);
        latch_model();
    endtask

    ////////////////////////////////
    // Reference model
    ////////////////////////////////

    function automatic bit box_drawn(int i, int thresh);
        int limit;
        int area;
        limit = (thresh == 0) ? DEF_THRESH : thresh;
        if (lat_min_x[i] == NO_BOX || lat_min_y[i] == NO_BOX) return 1'b0;
        if (lat_max_x[i] < lat_min_x[i] || lat_max_y[i] < lat_min_y[i]) return 1'b0;
        area = (lat_max_x[i] - lat_min_x[i] + 1) * (lat_max_y[i] - lat_min_y[i] + 1);
        return area >= limit;
    endfunction

    function automatic bit on_border(int x, int y, int thresh);
        for (int i = 0; i < N; i++) begin
            if (box_drawn(i, thresh)) begin
                if (((x == lat_min_x[i] || x == lat_max_x[i]) &&
                     y >= lat_min_y[i] && y <= lat_max_y[i]) ||
                    ((y == lat_min_y[i] || y == lat_max_y[i]) &&
                     x >= lat_min_x[i] && x <= lat_max_x[i]))
                    return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Checks one whole frame and raises mark_en_i at mark_line
    task automatic scan_frame(string test, int mark_line);
        int x;
        int y;
        int act_cnt;
        int hs_cnt;
        int vs_cnt;
        int exp_red;
        int exp_gb;
        bit mark;
        x = 0;
        y = 0;
        act_cnt = 0;
        hs_cnt = 0;
        vs_cnt = 0;
        @(negedge clk);
        while (draw_x !== '0 || draw_y !== '0) @(negedge clk);
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            if (n > 0) begin
                @(posedge clk);
                #5;
                if (y == mark_line && x == 0) mark_en = 1'b1;
                @(negedge clk);
            end
            mark = mark_en && (x < 16) && (y < 12) && on_border(x, y, int'(area_thresh));
            exp_red = mark ? 127 : int'(pixel);
            exp_gb = mark ? 0 : int'(pixel);
            check_value(test, "draw_x", x, 32'(draw_x));
            check_value(test, "draw_y", y, 32'(draw_y));
            check_value(test, "red", exp_red, 32'(red));
            check_value(test, "green", exp_gb, 32'(green));
            check_value(test, "blue", exp_gb, 32'(blue));
            act_cnt += int'(active);
            hs_cnt += int'(!hsync);
            vs_cnt += int'(!vsync);
            if (x == H_TOTAL - 1) begin
                check_value(test, "active cycles in line", (y < 12) ? 16 : 0, act_cnt);
                check_value(test, "hsync low cycles in line", 3, hs_cnt);
                act_cnt = 0;
                hs_cnt = 0;
                x = 0;
                y++;
            end else begin
                x++;
            end
        end
        check_value(test, "vsync low cycles in frame", 2 * H_TOTAL, vs_cnt);
    endtask

    ////////////////////////////////
    // Directed tests
    ////////////////////////////////

    // Called right after reset release while the counters are still zero
    task automatic test_raster();
        check_value("raster", "hsync after reset", 1, 32'(hsync));
        check_value("raster", "vsync after reset", 1, 32'(vsync));
        check_value("raster", "active after reset", 1, 32'(active));
    endtask

    task automatic test_before_sample();
        area_thresh = '0;
        mark_en = 1'b1;
        drive_box(4, 0, 15, 0, 11);
        scan_frame("before_sample", -1);
    endtask

    task automatic test_outline();
        @(posedge clk);
        #5;
        clear_boxes();
        drive_box(0, 1, 6, 1, 5);
        drive_box(5, 9, 12, 6, 9);
        wait_sample();
        scan_frame("outline", -1);
    endtask

    task automatic test_filter();
        @(posedge clk);
        #5;
        clear_boxes();
        drive_box(1, 5, 7, 2, 4);
        drive_box(2, 10, 8, 3, 6);
        drive_box(3, NO_BOX, 14, 1, 10);
        wait_sample();
        scan_frame("filter_default", -1);
        @(posedge clk);
        #5;
        area_thresh = 15'd4;
        scan_frame("filter_thresh4", -1);
    endtask

    task automatic test_mark_disable();
        @(posedge clk);
        #5;
        mark_en = 1'b0;
        scan_frame("mark_off", -1);
        scan_frame("mark_restore", 3);
    endtask

    initial begin
        reset = 1'b1;
        area_thresh = '0;
        mark_en = 1'b0;
        pixel = '0;
        clear_boxes();
        latch_model();
        repeat (8) @(posedge clk);
        #5;
        reset = 1'b0;
        test_raster();
        test_before_sample();
        test_outline();
        test_filter();
        test_mark_disable();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
